// File: dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// address bus and data word share one width
`define DC_ADDR_W   32

// byte offset inside the one-word line
`define DC_OFFSET_W 2

// 16 sets
`define DC_INDEX_W  4

// associativity, the tree logic assumes four
`define DC_WAYS     4

// whatever is left above index and offset
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

// File: dcache_pkg.sv
package dcache_pkg;

`include "dcache_params.svh"

    // miss controller states
    typedef enum logic [1:0] {
        DC_IDLE      = 2'd0, // hits are served here
        DC_WRITE_MEM = 2'd1, // dirty victim going out
        DC_READ_MEM  = 2'd2  // refill of the missed word
    } dc_state_e;

    // way number within a set
    typedef logic [1:0] dc_way_t;

    // stored or requested tag
    typedef logic [`DC_TAG_W-1:0] dc_tag_t;

    // set number
    typedef logic [`DC_INDEX_W-1:0] dc_index_t;

endpackage

// File: dcache_way_lookup.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_way_lookup (
    input  dcache_pkg::dc_tag_t                req_tag,
    input  logic [`DC_WAYS-1:0]                line_valid,
    input  dcache_pkg::dc_tag_t [`DC_WAYS-1:0] line_tags,
    input  dcache_pkg::dc_way_t                victim,
    output logic                               hit,
    output dcache_pkg::dc_way_t                way
);
    import dcache_pkg::*;

    logic [`DC_WAYS-1:0] match;   // per-way tag hit
    dc_way_t             hit_way; // encoded match

    // all four compares in parallel
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            // invalid line never hits, whatever its stale tag
            match[w] = line_valid[w] && (line_tags[w] == req_tag);
        end
    end

    assign hit = |match;

    // walk down so the lowest matching way is the last written
    always_comb begin
        hit_way = '0;
        for (int w = `DC_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = dc_way_t'(w);
            end
        end
    end

    // on a miss the replacement tree names the way to evict
    assign way = hit ? hit_way : victim;

endmodule

// File: dcache_plru_tree.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_plru_tree (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::dc_index_t index,
    input  logic                  touch,
    input  dcache_pkg::dc_way_t   touch_way,
    output dcache_pkg::dc_way_t   victim
);
    import dcache_pkg::*;

    localparam int n_sets = 1 << `DC_INDEX_W;

    // bit 2 is the root
    // bit 1 picks within ways 0/1, bit 0 within ways 2/3
    logic [2:0] tree_table [n_sets];
    logic [2:0] cur;  // tree of the addressed set
    logic [2:0] nxt;  // same tree after the touch
    dc_way_t    pick;

    assign cur = tree_table[index];

    // root selects the half, pair bit selects inside it
    always_comb begin
        if (cur[2]) begin
            pick = {1'b1, cur[0]};
        end else begin
            pick = {1'b0, cur[1]};
        end
    end

    assign victim = pick;

    // point every node on the path away from the used way
    always_comb begin
        nxt    = cur;
        nxt[2] = ~touch_way[1];     // root away from the touched half
        if (touch_way[1]) begin
            nxt[0] = ~touch_way[0]; // high pair
        end else begin
            nxt[1] = ~touch_way[0]; // low pair
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < n_sets; s++) begin
                tree_table[s] <= 3'b000;
            end
        end else if (touch) begin
            tree_table[index] <= nxt;  // once per finished access
        end
    end

endmodule

// File: dcache_line_store.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_line_store (
    input  logic                               clk,
    input  logic                               rst,
    input  dcache_pkg::dc_index_t              index,
    input  dcache_pkg::dc_tag_t                req_tag,
    input  dcache_pkg::dc_way_t                way,
    input  logic                               cpu_wr,
    input  logic [1:0]                         cpu_size,
    input  logic [`DC_OFFSET_W-1:0]            byte_sel,
    input  logic [`DC_ADDR_W-1:0]              cpu_wdata,
    input  logic [`DC_ADDR_W-1:0]              mem_rdata,
    input  logic                               fill,
    input  logic                               access,
    output logic [`DC_WAYS-1:0]                line_valid,
    output dcache_pkg::dc_tag_t [`DC_WAYS-1:0] line_tags,
    output logic                               sel_dirty,
    output dcache_pkg::dc_tag_t                sel_tag,
    output logic [`DC_ADDR_W-1:0]              sel_data
);
    import dcache_pkg::*;

    localparam int n_sets = 1 << `DC_INDEX_W;

    logic [`DC_WAYS-1:0]   valid_arr [n_sets];            // one bit per way
    logic [`DC_WAYS-1:0]   dirty_arr [n_sets];
    dc_tag_t               tag_arr   [n_sets][`DC_WAYS];
    logic [`DC_ADDR_W-1:0] data_arr  [n_sets][`DC_WAYS];  // one word per line

    logic [3:0]            lane_en;    // store byte mask
    logic [`DC_ADDR_W-1:0] base_word;  // word the store lands on
    logic [`DC_ADDR_W-1:0] merged;
    logic [`DC_ADDR_W-1:0] wr_word;
    logic                  data_we;

    // whole set goes to the lookup
    assign line_valid = valid_arr[index];

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            line_tags[w] = tag_arr[index][w];
        end
    end

    // chosen way for write-back and read data
    assign sel_dirty = dirty_arr[index][way];
    assign sel_tag   = tag_arr[index][way];
    assign sel_data  = data_arr[index][way];

    // size 0 byte, 1 half, 2 word
    always_comb begin
        case (cpu_size)
            2'd0:    lane_en = 4'b0001 << byte_sel;
            2'd1:    lane_en = byte_sel[1] ? 4'b1100 : 4'b0011;
            default: lane_en = 4'b1111;
        endcase
    end

    // refill merges into the incoming word, hit into the stored one
    assign base_word = fill ? mem_rdata : sel_data;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = lane_en[b] ? cpu_wdata[8*b +: 8] : base_word[8*b +: 8];
        end
    end

    assign wr_word = cpu_wr ? merged : mem_rdata;  // plain refill for loads
    assign data_we = fill | (access & cpu_wr);

    // line state
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < n_sets; s++) begin
                valid_arr[s] <= '0;
                dirty_arr[s] <= '0;
            end
        end else if (fill) begin
            valid_arr[index][way] <= 1'b1;
            dirty_arr[index][way] <= cpu_wr;  // store miss leaves it dirty
        end else if (access && cpu_wr) begin
            dirty_arr[index][way] <= 1'b1;
        end
    end

    // tag and payload
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_arr[index][way] <= req_tag;
        end
        if (data_we) begin
            data_arr[index][way] <= wr_word;
        end
    end

endmodule

// File: dcache_miss_ctrl.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_miss_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req,
    input  logic [`DC_ADDR_W-1:0] cpu_addr,
    input  logic                  hit,
    input  logic                  sel_dirty,
    input  dcache_pkg::dc_tag_t   sel_tag,
    input  logic [`DC_ADDR_W-1:0] sel_data,
    input  dcache_pkg::dc_index_t index,
    input  logic [`DC_ADDR_W-1:0] mem_rdata,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok,
    output logic [`DC_ADDR_W-1:0] cpu_rdata,
    output logic                  cpu_addr_ok,
    output logic                  cpu_data_ok,
    output logic                  mem_req,
    output logic                  mem_wr,
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic [`DC_ADDR_W-1:0] mem_wdata,
    output logic                  fill,
    output logic                  access
);
    import dcache_pkg::*;

    dc_state_e state;
    dc_state_e state_nxt;
    logic      addr_done;  // memory took the address, data still due
    logic      in_idle;
    logic      in_write;
    logic      in_read;
    logic      cpu_hit;    // request served from the arrays this cycle

    assign in_idle  = (state == DC_IDLE);
    assign in_write = (state == DC_WRITE_MEM);
    assign in_read  = (state == DC_READ_MEM);
    assign cpu_hit  = in_idle & cpu_req & hit;

    always_comb begin
        state_nxt = state;
        case (state)
            DC_IDLE: begin
                // victim decides whether a write-back comes first
                if (cpu_req && !hit) begin
                    state_nxt = sel_dirty ? DC_WRITE_MEM : DC_READ_MEM;
                end
            end
            DC_WRITE_MEM: begin
                if (mem_data_ok) begin
                    state_nxt = DC_READ_MEM;  // old word is out, now fetch
                end
            end
            DC_READ_MEM: begin
                if (mem_data_ok) begin
                    state_nxt = DC_IDLE;
                end
            end
            default: state_nxt = DC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= DC_IDLE;
            addr_done <= 1'b0;
        end else begin
            state <= state_nxt;
            // data_ok ends the transfer even with addr_ok in the same cycle
            if (mem_data_ok) begin
                addr_done <= 1'b0;
            end else if (mem_req && mem_addr_ok) begin
                addr_done <= 1'b1;
            end
        end
    end

    // request held until the address is taken
    assign mem_req   = ~in_idle & ~addr_done;
    assign mem_wr    = in_write;
    assign mem_addr  = in_write ? {sel_tag, index, {`DC_OFFSET_W{1'b0}}}
                                : {cpu_addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    assign mem_wdata = sel_data;  // victim word

    // write-back stays invisible to the processor
    assign cpu_addr_ok = cpu_hit | (in_read & mem_req & mem_addr_ok);
    assign cpu_data_ok = cpu_hit | (in_read & mem_data_ok);
    assign cpu_rdata   = in_read ? mem_rdata : sel_data;

    assign fill   = in_read & mem_data_ok;  // line written at this edge
    assign access = cpu_hit;

endmodule

// File: dcache.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache (
    input  logic                  clk,
    input  logic                  rst,
    // processor port
    input  logic                  cpu_req,
    input  logic                  cpu_wr,
    input  logic [1:0]            cpu_size,
    input  logic [`DC_ADDR_W-1:0] cpu_addr,
    input  logic [`DC_ADDR_W-1:0] cpu_wdata,
    output logic [`DC_ADDR_W-1:0] cpu_rdata,
    output logic                  cpu_addr_ok,
    output logic                  cpu_data_ok,
    // memory port, whole words only
    output logic                  mem_req,
    output logic                  mem_wr,
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic [`DC_ADDR_W-1:0] mem_wdata,
    input  logic [`DC_ADDR_W-1:0] mem_rdata,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok
);
    import dcache_pkg::*;

    dc_tag_t                 req_tag;
    dc_index_t               index;
    logic [`DC_OFFSET_W-1:0] byte_sel;
    logic [`DC_WAYS-1:0]     line_valid;
    dc_tag_t [`DC_WAYS-1:0]  line_tags;
    logic                    hit;
    dc_way_t                 way;      // hit way or victim
    dc_way_t                 victim;
    logic                    sel_dirty;
    dc_tag_t                 sel_tag;
    logic [`DC_ADDR_W-1:0]   sel_data;
    logic                    fill;
    logic                    access;

    // address stays stable for the whole request
    assign req_tag  = cpu_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign index    = cpu_addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign byte_sel = cpu_addr[`DC_OFFSET_W-1:0];

    dcache_way_lookup u_lookup (
        .req_tag    (req_tag),
        .line_valid (line_valid),
        .line_tags  (line_tags),
        .victim     (victim),
        .hit        (hit),
        .way        (way)
    );

    // data_ok doubles as the touch, on hits and at refill end
    dcache_plru_tree u_plru (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .touch      (cpu_data_ok),
        .touch_way  (way),
        .victim     (victim)
    );

    dcache_line_store u_store (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .req_tag    (req_tag),
        .way        (way),
        .cpu_wr     (cpu_wr),
        .cpu_size   (cpu_size),
        .byte_sel   (byte_sel),
        .cpu_wdata  (cpu_wdata),
        .mem_rdata  (mem_rdata),
        .fill       (fill),
        .access     (access),
        .line_valid (line_valid),
        .line_tags  (line_tags),
        .sel_dirty  (sel_dirty),
        .sel_tag    (sel_tag),
        .sel_data   (sel_data)
    );

    dcache_miss_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .hit         (hit),
        .sel_dirty   (sel_dirty),
        .sel_tag     (sel_tag),
        .sel_data    (sel_data),
        .index       (index),
        .mem_rdata   (mem_rdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .cpu_rdata   (cpu_rdata),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .fill        (fill),
        .access      (access)
    );

endmodule

// File: dcache_tb.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_tb;

    localparam int n_req       = 600;
    localparam int req_timeout = 50;  // cycles allowed for one request

    logic                  clk, rst;
    logic                  cpu_req, cpu_wr, cpu_addr_ok, cpu_data_ok;
    logic [1:0]            cpu_size;
    logic [`DC_ADDR_W-1:0] cpu_addr, cpu_wdata, cpu_rdata;
    logic                  mem_req, mem_wr, mem_addr_ok, mem_data_ok;
    logic [`DC_ADDR_W-1:0] mem_addr, mem_wdata, mem_rdata;

    logic [15:0]          lfsr;
    logic [31:0]          backing [128];  // memory behind the cache over a 512-byte space
    logic [31:0]          arch    [128];  // value a load has to return
    logic [`DC_TAG_W-1:0] m_tag   [16][4];
    logic                 m_valid [16][4];
    logic                 m_dirty [16][4];
    logic                 t_root  [16];   // tree model per set
    logic                 t_lo    [16];   // picks within ways 0/1
    logic                 t_hi    [16];   // picks within ways 2/3

    logic                 rsp_busy;       // responder holds an accepted transfer
    int                   rsp_wait;       // cycles left before the next strobe
    logic                 rsp_wr;
    logic [31:0]          rsp_addr, rsp_wdata;
    logic                 x_wr   [$];     // transfers seen during one request
    logic [31:0]          x_addr [$];
    logic [31:0]          x_data [$];
    int                   n_acc;          // addresses taken during one request
    int                   n_hit, n_wb;

    dcache UUT (.*);

    always #50 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[15]};  // one step per bit
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // byte lanes written by a store of the given size at the given offset
    function automatic logic [31:0] merge_store(input logic [31:0] old_word,
                                                input logic [31:0] wdata,
                                                input logic [1:0] size, input logic [1:0] off);
        logic [31:0] res;
        logic        lane;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            case (size)
                2'd0:    lane = (b[1:0] == off);   // one byte
                2'd1:    lane = (b[1] == off[1]);  // low or high half
                default: lane = 1'b1;
            endcase
            if (lane) res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    // memory side for one cycle right after the falling edge
    task automatic respond_mem();
        logic [31:0] r;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        if (!rsp_busy && mem_req) begin
            if (rsp_wait == 0) begin
                mem_addr_ok = 1'b1;
                rsp_wr      = mem_wr;
                rsp_addr    = mem_addr;
                rsp_wdata   = mem_wdata;
                rsp_busy    = 1'b1;
                n_acc++;
                take_bits(2, r);
                rsp_wait = int'(r);  // 0 means data in the same cycle
            end else begin
                rsp_wait--;
            end
        end else if (rsp_busy) begin
            rsp_wait--;
        end
        if (rsp_busy && rsp_wait == 0) begin
            mem_data_ok = 1'b1;
            if (rsp_wr) backing[rsp_addr[8:2]] = rsp_wdata;
            else mem_rdata = backing[rsp_addr[8:2]];
            x_wr.push_back(rsp_wr);
            x_addr.push_back(rsp_addr);
            x_data.push_back(rsp_wdata);
            rsp_busy = 1'b0;
            take_bits(2, r);
            rsp_wait = int'(r);  // address delay of the next transfer
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        cpu_req = 1'b0;
        respond_mem();
        #1;
        check_value("idle mem_req", 32'd0, 32'(mem_req));
        check_value("idle cpu_addr_ok", 32'd0, 32'(cpu_addr_ok));
        check_value("idle cpu_data_ok", 32'd0, 32'(cpu_data_ok));
    endtask

    task automatic do_request(input logic wr, input logic [1:0] size,
                              input logic [31:0] addr, input logic [31:0] wdata);
        logic [3:0]           s;
        logic [`DC_TAG_W-1:0] t;
        logic [1:0]           w;
        logic                 phit, pdirty, done;
        logic [31:0]          vaddr;
        int                   cycles;
        s    = addr[5:2];
        t    = addr[31:6];
        phit = 1'b0;
        w    = t_root[s] ? {1'b1, t_hi[s]} : {1'b0, t_lo[s]};  // victim unless a way hits
        for (int i = 3; i >= 0; i--) begin
            if (m_valid[s][i] && m_tag[s][i] == t) begin
                phit = 1'b1;
                w    = i[1:0];  // lowest matching way wins
            end
        end
        pdirty = !phit && m_valid[s][w] && m_dirty[s][w];
        vaddr  = {m_tag[s][w], s, 2'b00};
        x_wr.delete();
        x_addr.delete();
        x_data.delete();
        n_acc  = 0;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < req_timeout) begin
            @(negedge clk);
            cpu_req   = 1'b1;  // all inputs held until data_ok
            cpu_wr    = wr;
            cpu_size  = size;
            cpu_addr  = addr;
            cpu_wdata = wdata;
            respond_mem();
            #1;
            if (cycles == 0) begin
                check_value("hit data_ok in first cycle", 32'(phit), 32'(cpu_data_ok));
                check_value("hit addr_ok in first cycle", 32'(phit), 32'(cpu_addr_ok));
                check_value("no mem_req from idle", 32'd0, 32'(mem_req));
            end else begin
                // processor sees only the refill address being taken
                check_value("addr_ok with refill address",
                            32'(mem_addr_ok && n_acc == (pdirty ? 2 : 1)), 32'(cpu_addr_ok));
                if (cycles == 1) begin
                    check_value("miss raises mem_req", 32'd1, 32'(mem_req));
                end
            end
            if (cpu_data_ok) begin
                done = 1'b1;
                if (!wr) check_value("load data", arch[addr[8:2]], cpu_rdata);
            end
            cycles++;
        end
        if (!done) begin
            $display("request to %h (write %0d) saw no cpu_data_ok in %0d cycles",
                     addr, wr, req_timeout);
            $display("TEST FAILED");
            $fatal(1, "cache stalled");
        end
        check_value("memory transfer count", 32'(pdirty ? 2 : (phit ? 0 : 1)),
                    32'(x_addr.size()));
        if (pdirty) begin
            check_value("write-back is a write", 32'd1, 32'(x_wr[0]));
            check_value("write-back address", vaddr, x_addr[0]);
            check_value("write-back data", arch[vaddr[8:2]], x_data[0]);
            n_wb++;
        end
        if (!phit) begin
            check_value("refill is a read", 32'd0, 32'(x_wr[x_wr.size()-1]));
            check_value("refill address", {addr[31:2], 2'b00}, x_addr[x_addr.size()-1]);
            m_valid[s][w] = 1'b1;
            m_tag[s][w]   = t;
            m_dirty[s][w] = wr;  // store miss merges during refill
        end else begin
            n_hit++;
            if (wr) m_dirty[s][w] = 1'b1;
        end
        t_root[s] = ~w[1];       // point away from the used way
        if (w[1]) t_hi[s] = ~w[0];
        else t_lo[s] = ~w[0];
        if (wr) arch[addr[8:2]] = merge_store(arch[addr[8:2]], wdata, size, addr[1:0]);
    endtask

    initial begin : main
        logic [31:0] r, addr, wdata;
        logic [1:0]  size;
        clk  = 1'b0;
        rst  = 1'b1;
        lfsr = 16'd15708;
        {cpu_req, cpu_wr, cpu_size, cpu_addr, cpu_wdata} = '0;
        {mem_rdata, mem_addr_ok, mem_data_ok} = '0;
        rsp_busy = 1'b0;
        rsp_wait = 0;
        n_acc    = 0;
        n_hit    = 0;
        n_wb     = 0;
        for (int i = 0; i < 128; i++) begin
            backing[i] = 32'(i) * 32'h9E37_79B9 ^ 32'h5A5A_0F0F;  // hash of the word address
            arch[i]    = backing[i];
        end
        for (int s = 0; s < 16; s++) begin
            {t_root[s], t_lo[s], t_hi[s]} = 3'b000;
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) idle_cycle();  // nothing moves without a request
        for (int n = 0; n < n_req; n++) begin
            take_bits(2, r);
            size = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
            take_bits(9, r);
            addr = {23'd0, r[8:0]};  // 3 tag bits, 4 index bits, offset
            if (size == 2'd2) addr[1:0] = 2'b00;
            if (size == 2'd1) addr[0] = 1'b0;
            take_bits(32, wdata);
            take_bits(1, r);
            do_request(r[0], size, addr, wdata);
            take_bits(1, r);
            if (r[0]) idle_cycle();  // random gap between requests
        end
        $display("%0d requests, %0d hits, %0d write-backs", n_req, n_hit, n_wb);
        if (n_hit == 0 || n_wb == 0) begin
            $display("random stimulus never reached a hit or a dirty eviction");
            $display("TEST FAILED");
            $fatal(1, "stimulus too weak");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: dcache.f
+incdir+.
dcache_pkg.sv
dcache_way_lookup.sv
dcache_plru_tree.sv
dcache_line_store.sv
dcache_miss_ctrl.sv
dcache.sv
dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := dcache_tb
FILELIST  := dcache.f
OBJ_DIR   := obj_dir
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) dcache_params.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
